/* common/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath and counter widths
`define CORE_XLEN      32
`define CORE_CNT_W     5
`define CORE_REG_W     5
`define CORE_IMM_W     12

`define CORE_RESET_PC  32'h0000_0000

`define CORE_OPC_OP    7'b0110011
`define CORE_OPC_OPIMM 7'b0010011

`define CORE_F3_ADD    3'b000
`define CORE_F3_XOR    3'b100
`define CORE_F3_OR     3'b110
`define CORE_F3_AND    3'b111

`endif

/* common/core_pkg.sv */
`include "core_params.svh"

package core_pkg;

   // Register-register layout
   typedef struct packed {
      logic [6:0]             funct7;
      logic [`CORE_REG_W-1:0] rs2;
      logic [`CORE_REG_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [`CORE_REG_W-1:0] rd;
      logic [6:0]             opcode;
   } instr_r_t;

   // Register-immediate layout
   typedef struct packed {
      logic [`CORE_IMM_W-1:0] imm;
      logic [`CORE_REG_W-1:0] rs1;
      logic [2:0]             funct3;
      logic [`CORE_REG_W-1:0] rd;
      logic [6:0]             opcode;
   } instr_i_t;

   typedef union packed {
      instr_r_t r;
      instr_i_t i;
   } instr_u;

   typedef struct packed {
      logic       sub;
      logic [1:0] bool_op;
      logic       use_imm;
      logic       rd_sel_bool;
   } alu_ctrl_t;

   typedef struct packed {
      logic en;
      logic first;
      logic done;
   } cnt_t;

endpackage

/* hw/control/core_state.sv */
`timescale 1ns/1ps

module core_state import core_pkg::*; (
   input  logic i_clk,
   input  logic i_arst_n,
   input  logic i_ibus_ack,
   input  logic i_rf_ready,
   input  cnt_t i_cnt,
   output logic o_ibus_cyc,
   output logic o_rf_rreq,
   output logic o_cnt_start
);

   localparam logic [1:0] S_FETCH      = 2'd0;
   localparam logic [1:0] S_READ_REQ   = 2'd1;
   localparam logic [1:0] S_WAIT_READY = 2'd2;
   localparam logic [1:0] S_EXECUTE    = 2'd3;

   logic [1:0] state;
   logic       rf_pending;

   // Ready is honoured both in the request cycle and while waiting
   assign rf_pending  = (state == S_READ_REQ) | (state == S_WAIT_READY);
   assign o_cnt_start = rf_pending & i_rf_ready;
   assign o_ibus_cyc  = (state == S_FETCH);
   assign o_rf_rreq   = (state == S_READ_REQ);

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= S_FETCH;
      end else begin
         case (state)
            S_FETCH: begin
               if (i_ibus_ack)
                  state <= S_READ_REQ;
            end
            S_READ_REQ: begin
               state <= i_rf_ready ? S_EXECUTE : S_WAIT_READY;
            end
            S_WAIT_READY: begin
               if (i_rf_ready)
                  state <= S_EXECUTE;
            end
            default: begin
               // Back to fetch after the last bit
               if (i_cnt.done)
                  state <= S_FETCH;
            end
         endcase
      end
   end

endmodule

/* hw/control/core_cnt.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module core_cnt import core_pkg::*; (
   input  logic i_clk,
   input  logic i_arst_n,
   input  logic i_start,
   output cnt_t o_cnt,
   output logic o_cnt2
);

   logic                   run;
   logic [`CORE_CNT_W-1:0] cnt;
   logic                   last;

   assign last = (cnt == {`CORE_CNT_W{1'b1}});

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         run <= 1'b0;
         cnt <= '0;
      end else begin
         if (i_start)
            run <= 1'b1;
         else if (run & last)
            run <= 1'b0;
         // Wraps to zero after the last step
         if (run)
            cnt <= cnt + 1'b1;
      end
   end

   assign o_cnt.en    = run;
   assign o_cnt.first = run & (cnt == '0);
   assign o_cnt.done  = run & last;
   assign o_cnt2      = run & (cnt == `CORE_CNT_W'(2));

endmodule

/* hw/control/core_decode.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module core_decode import core_pkg::*; (
   input  logic                   i_clk,
   input  logic                   i_arst_n,
   input  logic                   i_ibus_ack,
   input  instr_u                 i_ibus_rdt,
   input  cnt_t                   i_cnt,
   output alu_ctrl_t              o_alu_ctrl,
   output logic [`CORE_REG_W-1:0] o_rreg0,
   output logic [`CORE_REG_W-1:0] o_rreg1,
   output logic [`CORE_REG_W-1:0] o_wreg0,
   output logic                   o_wen0
);

   logic [`CORE_REG_W-1:0] rs1_q;
   logic [`CORE_REG_W-1:0] rs2_q;
   logic [`CORE_REG_W-1:0] rd_q;
   logic [2:0]             funct3_q;
   logic                   f7_sub_q;
   logic                   op_reg_q;
   logic                   op_imm_q;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         rs1_q    <= '0;
         rs2_q    <= '0;
         rd_q     <= '0;
         funct3_q <= `CORE_F3_ADD;
         f7_sub_q <= 1'b0;
         op_reg_q <= 1'b0;
         op_imm_q <= 1'b0;
      end else if (i_ibus_ack) begin
         rs1_q    <= i_ibus_rdt.r.rs1;
         rs2_q    <= i_ibus_rdt.r.rs2;
         rd_q     <= i_ibus_rdt.r.rd;
         funct3_q <= i_ibus_rdt.r.funct3;
         f7_sub_q <= i_ibus_rdt.r.funct7[5];
         op_reg_q <= (i_ibus_rdt.r.opcode == `CORE_OPC_OP);
         op_imm_q <= (i_ibus_rdt.i.opcode == `CORE_OPC_OPIMM);
      end
   end

   // bool_op is 00 for xor, 10 for or and 11 for and
   always_comb begin
      case (funct3_q)
         `CORE_F3_XOR: o_alu_ctrl.bool_op = 2'b00;
         `CORE_F3_OR:  o_alu_ctrl.bool_op = 2'b10;
         `CORE_F3_AND: o_alu_ctrl.bool_op = 2'b11;
         default:      o_alu_ctrl.bool_op = 2'b00;
      endcase
   end

   // funct7 only carries sub for register ops
   assign o_alu_ctrl.sub         = op_reg_q & f7_sub_q;
   assign o_alu_ctrl.use_imm     = op_imm_q;
   assign o_alu_ctrl.rd_sel_bool = (funct3_q != `CORE_F3_ADD);

   assign o_rreg0 = rs1_q;
   assign o_rreg1 = rs2_q;
   assign o_wreg0 = rd_q;
   assign o_wen0  = i_cnt.en & (|rd_q);

endmodule

/* hw/datapath/core_immdec.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module core_immdec import core_pkg::*; (
   input  logic   i_clk,
   input  logic   i_arst_n,
   input  logic   i_ibus_ack,
   input  instr_u i_ibus_rdt,
   input  cnt_t   i_cnt,
   output logic   o_imm
);

   logic [`CORE_IMM_W-1:0] imm_sr;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         imm_sr <= '0;
      end else if (i_ibus_ack) begin
         imm_sr <= i_ibus_rdt.i.imm;
      end else if (i_cnt.en) begin
         // Sign bit stays put and fills the upper steps
         imm_sr <= {imm_sr[`CORE_IMM_W-1], imm_sr[`CORE_IMM_W-1:1]};
      end
   end

   assign o_imm = imm_sr[0];

endmodule

/* hw/datapath/core_alu.sv */
`timescale 1ns/1ps

module core_alu import core_pkg::*; (
   input  logic      i_clk,
   input  logic      i_arst_n,
   input  cnt_t      i_cnt,
   input  alu_ctrl_t i_ctrl,
   input  logic      i_rs1,
   input  logic      i_rs2,
   input  logic      i_imm,
   output logic      o_rd
);

   logic op_b;
   logic b_add;
   logic carry;
   logic carry_in;
   logic sum;
   logic bool_rd;

   assign op_b  = i_ctrl.use_imm ? i_imm : i_rs2;
   assign b_add = op_b ^ i_ctrl.sub;

   // Carry-in of one at step 0 completes the two's complement
   assign carry_in = i_cnt.first ? i_ctrl.sub : carry;
   assign sum      = i_rs1 ^ b_add ^ carry_in;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n)
         carry <= 1'b0;
      else if (i_cnt.en)
         carry <= (i_rs1 & b_add) | (carry_in & (i_rs1 ^ b_add));
   end

   always_comb begin
      case (i_ctrl.bool_op)
         2'b10:   bool_rd = i_rs1 | op_b;
         2'b11:   bool_rd = i_rs1 & op_b;
         default: bool_rd = i_rs1 ^ op_b;
      endcase
   end

   assign o_rd = i_ctrl.rd_sel_bool ? bool_rd : sum;

endmodule

/* hw/datapath/core_pc.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module core_pc import core_pkg::*; (
   input  logic                  i_clk,
   input  logic                  i_arst_n,
   input  cnt_t                  i_cnt,
   input  logic                  i_cnt2,
   output logic [`CORE_XLEN-1:0] o_ibus_adr
);

   logic [`CORE_XLEN-1:0] pc;
   logic                  carry;
   logic                  carry_in;
   logic                  sum;

   // Addend is the constant 4, so only bit 2 is set
   assign carry_in = carry & ~i_cnt.first;
   assign sum      = pc[0] ^ i_cnt2 ^ carry_in;

   always_ff @(posedge i_clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         pc    <= `CORE_RESET_PC;
         carry <= 1'b0;
      end else if (i_cnt.en) begin
         pc    <= {sum, pc[`CORE_XLEN-1:1]};
         carry <= (pc[0] & i_cnt2) | (carry_in & (pc[0] ^ i_cnt2));
      end
   end

   assign o_ibus_adr = pc;

endmodule

/* hw/core_top.sv */
`timescale 1ns/1ps

module core_top import core_pkg::*; (
   input  logic        clk,
   input  logic        i_arst_n,
   output logic [31:0] o_ibus_adr,
   output logic        o_ibus_cyc,
   input  logic [31:0] i_ibus_rdt,
   input  logic        i_ibus_ack,
   output logic        o_rf_rreq,
   input  logic        i_rf_ready,
   output logic [4:0]  o_rreg0,
   output logic [4:0]  o_rreg1,
   output logic [4:0]  o_wreg0,
   output logic        o_wen0,
   output logic        o_wdata0,
   input  logic        i_rdata0,
   input  logic        i_rdata1
);

   cnt_t      cnt;
   logic      cnt2;
   logic      cnt_start;
   alu_ctrl_t alu_ctrl;
   logic      imm;

   core_state u_state (
      .i_clk       (clk),
      .i_arst_n    (i_arst_n),
      .i_ibus_ack  (i_ibus_ack),
      .i_rf_ready  (i_rf_ready),
      .i_cnt       (cnt),
      .o_ibus_cyc  (o_ibus_cyc),
      .o_rf_rreq   (o_rf_rreq),
      .o_cnt_start (cnt_start)
   );

   core_cnt u_cnt (
      .i_clk    (clk),
      .i_arst_n (i_arst_n),
      .i_start  (cnt_start),
      .o_cnt    (cnt),
      .o_cnt2   (cnt2)
   );

   core_decode u_decode (
      .i_clk      (clk),
      .i_arst_n   (i_arst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_cnt      (cnt),
      .o_alu_ctrl (alu_ctrl),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .o_wreg0    (o_wreg0),
      .o_wen0     (o_wen0)
   );

   core_immdec u_immdec (
      .i_clk      (clk),
      .i_arst_n   (i_arst_n),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_cnt      (cnt),
      .o_imm      (imm)
   );

   // Result bit goes straight to the RF write lane
   core_alu u_alu (
      .i_clk    (clk),
      .i_arst_n (i_arst_n),
      .i_cnt    (cnt),
      .i_ctrl   (alu_ctrl),
      .i_rs1    (i_rdata0),
      .i_rs2    (i_rdata1),
      .i_imm    (imm),
      .o_rd     (o_wdata0)
   );

   core_pc u_pc (
      .i_clk      (clk),
      .i_arst_n   (i_arst_n),
      .i_cnt      (cnt),
      .i_cnt2     (cnt2),
      .o_ibus_adr (o_ibus_adr)
   );

endmodule

/* test/core_sva.sv */
`timescale 1ns/1ps

module core_sva (
   input logic clk,
   input logic i_arst_n,
   input logic o_ibus_cyc,
   input logic i_ibus_ack,
   input logic o_rf_rreq,
   input logic o_wen0
);

   int fail_cnt = 0;

   // No register write while fetching
   assert property (@(posedge clk) disable iff (!i_arst_n) !(o_ibus_cyc && o_wen0))
      else begin
         $error("o_ibus_cyc and o_wen0 high together");
         fail_cnt++;
      end

   assert property (@(posedge clk) disable iff (!i_arst_n) o_rf_rreq |=> !o_rf_rreq)
      else begin
         $error("o_rf_rreq longer than one cycle");
         fail_cnt++;
      end

   // Bus cycle held until acknowledged
   assert property (@(posedge clk) disable iff (!i_arst_n)
                    (o_ibus_cyc && !i_ibus_ack) |=> o_ibus_cyc)
      else begin
         $error("o_ibus_cyc dropped before i_ibus_ack");
         fail_cnt++;
      end

endmodule

bind core_top core_sva u_sva (
   .clk        (clk),
   .i_arst_n   (i_arst_n),
   .o_ibus_cyc (o_ibus_cyc),
   .i_ibus_ack (i_ibus_ack),
   .o_rf_rreq  (o_rf_rreq),
   .o_wen0     (o_wen0)
);

/* test/tb_core_top.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module tb_core_top import core_pkg::*; ();

   localparam int TIMEOUT = 50;

   logic        clk;
   logic        i_arst_n;
   logic [31:0] i_ibus_rdt;
   logic        i_ibus_ack;
   logic        i_rf_ready;
   logic        i_rdata0;
   logic        i_rdata1;
   logic [31:0] o_ibus_adr;
   logic        o_ibus_cyc;
   logic        o_rf_rreq;
   logic [4:0]  o_rreg0;
   logic [4:0]  o_rreg1;
   logic [4:0]  o_wreg0;
   logic        o_wen0;
   logic        o_wdata0;

   // Stimulus table
   string       t_name[$];
   logic [31:0] t_instr[$];
   logic [31:0] t_a[$];
   logic [31:0] t_b[$];
   logic [31:0] t_exp[$];
   int          t_rs1[$];
   int          t_rs2[$];
   int          t_rd[$];

   int          err_cnt = 0;
   int          timeout_cnt = 0;
   logic [15:0] lfsr_state = 16'd14868;

   core_top u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic draw_bits(input int n, output int val);
      val = 0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val = (val << 1) | lfsr_state[0];
      end
   endtask

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic add_r(input string name, input logic [6:0] f7, input logic [2:0] f3,
                        input int rs1, input int rs2, input int rd,
                        input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp);
      instr_u w;
      w.r.funct7 = f7;
      w.r.rs2    = rs2;
      w.r.rs1    = rs1;
      w.r.funct3 = f3;
      w.r.rd     = rd;
      w.r.opcode = `CORE_OPC_OP;
      t_name.push_back(name);
      t_instr.push_back(w);
      t_a.push_back(a);
      t_b.push_back(b);
      t_exp.push_back(exp);
      t_rs1.push_back(rs1);
      t_rs2.push_back(rs2);
      t_rd.push_back(rd);
   endtask

   // Junk on the rs2 lane that the immediate overrides
   task automatic add_i(input string name, input logic [11:0] imm, input logic [2:0] f3,
                        input int rs1, input int rd, input logic [31:0] a,
                        input logic [31:0] exp);
      instr_u w;
      w.i.imm    = imm;
      w.i.rs1    = rs1;
      w.i.funct3 = f3;
      w.i.rd     = rd;
      w.i.opcode = `CORE_OPC_OPIMM;
      t_name.push_back(name);
      t_instr.push_back(w);
      t_a.push_back(a);
      t_b.push_back(32'hDEAD_BEEF);
      t_exp.push_back(exp);
      t_rs1.push_back(rs1);
      t_rs2.push_back(int'(imm[4:0]));
      t_rd.push_back(rd);
   endtask

   task automatic wait_strobe(input bit want_rreq, output bit ok);
      int n;
      n  = 0;
      ok = 1'b0;
      while (n < TIMEOUT && !ok) begin
         if (want_rreq ? o_rf_rreq : o_ibus_cyc)
            ok = 1'b1;
         else begin
            @(negedge clk);
            n++;
         end
      end
      if (!ok) begin
         $display("Timeout: %s never went high", want_rreq ? "o_rf_rreq" : "o_ibus_cyc");
         timeout_cnt++;
      end
   endtask

   initial begin
      bit          ok;
      int          delay;
      int          wen_cnt;
      logic [31:0] result;

      i_arst_n   = 1'b0;
      i_ibus_rdt = '0;
      i_ibus_ack = 1'b0;
      i_rf_ready = 1'b0;
      i_rdata0   = 1'b0;
      i_rdata1   = 1'b0;

      add_r("add",        7'h00, `CORE_F3_ADD, 1, 2, 3, 32'h0000_0005, 32'h0000_0007, 32'h0000_000C);
      add_r("add_carry",  7'h00, `CORE_F3_ADD, 4, 5, 6, 32'hFFFF_FFFF, 32'h0000_0002, 32'h0000_0001);
      add_r("add_msb",    7'h00, `CORE_F3_ADD, 7, 8, 9, 32'h8000_0000, 32'h8000_0000, 32'h0000_0000);
      add_r("sub",        7'h20, `CORE_F3_ADD, 10, 11, 12, 32'h0000_000A, 32'h3, 32'h0000_0007);
      add_r("sub_borrow", 7'h20, `CORE_F3_ADD, 13, 14, 15, 32'h0000_0003, 32'h5, 32'hFFFF_FFFE);
      add_r("sub_zero",   7'h20, `CORE_F3_ADD, 16, 17, 18, 32'h0000_0000, 32'h1, 32'hFFFF_FFFF);
      add_r("and",        7'h00, `CORE_F3_AND, 19, 20, 21, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'hF000_F000);
      add_r("or",         7'h00, `CORE_F3_OR,  22, 23, 24, 32'hF0F0_0000, 32'h0F0F_1234, 32'hFFFF_1234);
      add_r("xor",        7'h00, `CORE_F3_XOR, 25, 26, 27, 32'hAAAA_5555, 32'hFFFF_0000, 32'h5555_5555);
      add_i("addi_max",   12'h7FF, `CORE_F3_ADD, 28, 29, 32'h0000_0001, 32'h0000_0800);
      add_i("addi_neg1",  12'hFFF, `CORE_F3_ADD, 30, 31, 32'h0000_0010, 32'h0000_000F);
      add_i("addi_min",   12'h800, `CORE_F3_ADD, 1, 2, 32'h0000_0000, 32'hFFFF_F800);
      add_i("andi",       12'h0F0, `CORE_F3_AND, 3, 4, 32'h1234_5678, 32'h0000_0070);
      add_i("andi_neg",   12'hFF0, `CORE_F3_AND, 5, 6, 32'h1234_5678, 32'h1234_5670);
      add_i("ori",        12'h123, `CORE_F3_OR,  7, 8, 32'hA000_0000, 32'hA000_0123);
      add_i("ori_neg",    12'h800, `CORE_F3_OR,  9, 10, 32'h0000_0055, 32'hFFFF_F855);
      add_i("xori",       12'h0FF, `CORE_F3_XOR, 11, 12, 32'h0000_0F0F, 32'h0000_0FF0);
      add_i("xori_not",   12'hFFF, `CORE_F3_XOR, 13, 14, 32'h1357_9BDF, 32'hECA8_6420);
      add_r("add_x0",     7'h00, `CORE_F3_ADD, 15, 16, 0, 32'h0000_0001, 32'h2, 32'h0000_0003);
      add_r("sub_msb",    7'h20, `CORE_F3_ADD, 17, 18, 19, 32'h0, 32'h8000_0000, 32'h8000_0000);

      repeat (8) @(negedge clk);
      i_arst_n = 1'b1;

      check_value("reset_cyc", 32'd1, {31'd0, o_ibus_cyc});
      check_value("reset_adr", `CORE_RESET_PC, o_ibus_adr);
      check_value("reset_rreq", 32'd0, {31'd0, o_rf_rreq});
      check_value("reset_wen", 32'd0, {31'd0, o_wen0});

      for (int idx = 0; idx < t_name.size(); idx++) begin
         wait_strobe(1'b0, ok);
         if (!ok)
            break;
         check_value({t_name[idx], "_adr"}, idx * 4, o_ibus_adr);
         i_ibus_rdt = t_instr[idx];
         i_ibus_ack = 1'b1;
         @(negedge clk);
         i_ibus_ack = 1'b0;
         i_ibus_rdt = '0;

         wait_strobe(1'b1, ok);
         if (!ok)
            break;
         check_value({t_name[idx], "_rreg0"}, t_rs1[idx], o_rreg0);
         check_value({t_name[idx], "_rreg1"}, t_rs2[idx], o_rreg1);
         check_value({t_name[idx], "_wreg0"}, t_rd[idx], o_wreg0);

         draw_bits(2, delay);
         repeat (delay) @(negedge clk);
         i_rf_ready = 1'b1;
         @(negedge clk);
         i_rf_ready = 1'b0;

         // Step 0 starts at this falling edge
         wen_cnt = 0;
         result  = '0;
         for (int k = 0; k < `CORE_XLEN; k++) begin
            i_rdata0 = t_a[idx][k];
            i_rdata1 = t_b[idx][k];
            @(posedge clk);
            result[k] = o_wdata0;
            if (o_wen0)
               wen_cnt++;
            @(negedge clk);
         end
         i_rdata0 = 1'b0;
         i_rdata1 = 1'b0;

         check_value({t_name[idx], "_rd"}, t_exp[idx], result);
         check_value({t_name[idx], "_wen_bits"}, (t_rd[idx] != 0) ? 32 : 0, wen_cnt);
      end

      if (timeout_cnt == 0) begin
         wait_strobe(1'b0, ok);
         check_value("final_adr", t_name.size() * 4, o_ibus_adr);
      end

      $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
               err_cnt, timeout_cnt, u_dut.u_sva.fail_cnt);
      if (err_cnt == 0 && timeout_cnt == 0 && u_dut.u_sva.fail_cnt == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* all.f */
+incdir+common
common/core_pkg.sv
hw/control/core_state.sv
hw/control/core_cnt.sv
hw/control/core_decode.sv
hw/datapath/core_immdec.sv
hw/datapath/core_alu.sv
hw/datapath/core_pc.sv
hw/core_top.sv
test/core_sva.sv
test/tb_core_top.sv

/* Bender.yml */
package:
  name: core_serial

sources:
  - include_dirs:
      - common
    files:
      - common/core_pkg.sv
      - hw/control/core_state.sv
      - hw/control/core_cnt.sv
      - hw/control/core_decode.sv
      - hw/datapath/core_immdec.sv
      - hw/datapath/core_alu.sv
      - hw/datapath/core_pc.sv
      - hw/core_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/core_sva.sv
      - test/tb_core_top.sv
